// File: compile.f
hdl/lsuPkg.sv
hdl/memReqIf.sv
hdl/lsuReqTracker.sv
hdl/lsuIssue.sv
hdl/laneAlign.sv
hdl/lsuTop.sv
dv/lsuChk.sv
dv/lsuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module lsuTb -o simv
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "$out" | grep -qx "sim passed" || exit 1
exit 0

// File: dv/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;

  logic clkH, arstN, signExt, busy, loadValid, memReady;
  lsuPkg::memOpT    wrRdEn;
  lsuPkg::regIdxT   regIdx, pendIdx, loadIdx, expIdx;
  lsuPkg::argSizeT  argSize;
  logic [31:0]      addr;
  lsuPkg::dataT     wrData, loadData, memMosi, memMiso, hMosi, expMosi, expLoad, rnd;
  logic [31:3]      memAddr, hAddr;
  lsuPkg::laneMaskT memWrEn, memRdEn, hWr, hRd, expLanes;
  lsuPkg::dataT     memArr [256];
  lsuPkg::dataT     refMem [256];
  integer           seed = 32'he41d_1f4b;
  int               errCnt = 0, mark, stall = 0, waitN;
  logic             expRead, doneFlag, loadSeen;

  lsuTop #(.AddrLen(32)) dut (.*);

  initial begin
    clkH = 1'b0;
    forever #2 clkH = ~clkH;
  end

  task automatic checkVal(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED time=%0t %s exp=%h got=%h", $time, name, exp, got);
      errCnt++;
    end
  endtask

  // ****************************************
  // Reference model
  // ****************************************
  function automatic lsuPkg::laneMaskT shiftedLanes(logic [2:0] off, lsuPkg::argSizeT sz);
    return lsuPkg::laneMaskT'(((9'd1 << (1 << sz)) - 9'd1) << off);
  endfunction

  function automatic lsuPkg::dataT extendedLoad(lsuPkg::dataT word, logic [2:0] off,
                                                lsuPkg::argSizeT sz, logic sx);
    lsuPkg::dataT v;
    int nb;
    v  = word >> (8 * off);
    nb = 8 << sz;
    if (nb < 64) begin
      if (sx && v[nb-1]) v = v | ~((64'd1 << nb) - 64'd1);
      else v = v & ((64'd1 << nb) - 64'd1);
    end
    return v;
  endfunction

  // Memory model with 0 to 5 wait states unless a stall is forced
  initial begin
    memReady = 1'b0;
    memMiso  = '0;
    forever begin
      @(posedge clkH);
      if ((memWrEn | memRdEn) != '0) begin
        waitN = (stall != 0) ? stall : {$random(seed)} % 6;
        hAddr = memAddr;
        hMosi = memMosi;
        hWr   = memWrEn;
        hRd   = memRdEn;
        repeat (waitN) begin
          @(posedge clkH);
          if (stall != 0) begin
            checkVal("busy", busy, 1);
            checkVal("pendIdx", pendIdx, expIdx);
            checkVal("memAddr", memAddr, hAddr);
            checkVal("memMosi", memMosi, hMosi);
            checkVal("memWrEn", memWrEn, hWr);
            checkVal("memRdEn", memRdEn, hRd);
          end
        end
        #1 memReady = 1'b1;
        memMiso = memArr[memAddr[10:3]];
        @(posedge clkH);
        checkVal("memAddr", memAddr, addr >> 3);
        checkVal("memWrEn", memWrEn, expRead ? 8'h00 : expLanes);
        checkVal("memRdEn", memRdEn, expRead ? expLanes : 8'h00);
        if (!expRead) checkVal("memMosi", memMosi, expMosi);
        for (int i = 0; i < 8; i++)
          if (memWrEn[i]) memArr[memAddr[10:3]][8*i +: 8] = memMosi[8*i +: 8];
        doneFlag = 1'b1;
        #1 memReady = 1'b0;
        memMiso = '0;
      end
    end
  end

  // Load return compare
  always @(posedge clkH) begin
    if (loadValid) begin
      loadSeen = 1'b1;
      checkVal("loadValid", loadValid, expRead);
      checkVal("loadData", loadData, expLoad);
      checkVal("loadIdx", loadIdx, expIdx);
    end
  end

  task automatic access(lsuPkg::memOpT op, logic [31:0] a, lsuPkg::argSizeT sz,
                        logic sx, lsuPkg::dataT d);
    int t;
    expRead  = op[lsuPkg::OpRdBit];
    expLanes = shiftedLanes(a[2:0], sz);
    expMosi  = (d & ((sz == 3) ? '1 : ((64'd1 << (8 << sz)) - 1))) << (8 * a[2:0]);
    expLoad  = extendedLoad(refMem[a[10:3]], a[2:0], sz, sx);
    expIdx   = lsuPkg::regIdxT'($random(seed));
    if (!expRead)
      for (int i = 0; i < 8; i++)
        if (expLanes[i]) refMem[a[10:3]][8*i +: 8] = expMosi[8*i +: 8];
    doneFlag = 1'b0;
    loadSeen = 1'b0;
    wrRdEn   = op;
    addr     = a;
    argSize  = sz;
    signExt  = sx;
    wrData   = d;
    regIdx   = expIdx;
    @(posedge clkH);
    #1 wrRdEn = lsuPkg::OpNone;
    t = 0;
    while (!doneFlag && t < 100) begin
      @(posedge clkH);
      #1 t = t + 1;
    end
    if (!doneFlag) begin
      $display("timeout waiting for memReady completion at time %0t", $time);
      $display("sim failed");
      $finish;
    end
    @(posedge clkH);
    #1 checkVal("load returned", loadSeen, expRead);
    checkVal("busy", busy, 0);
  endtask

  initial begin
    arstN   = 1'b0;
    wrRdEn  = lsuPkg::OpNone;
    regIdx  = '0;
    argSize = lsuPkg::SizeByte;
    signExt = 1'b0;
    addr    = '0;
    wrData  = '0;
    for (int i = 0; i < 256; i++) begin
      memArr[i] = {i * 32'h9E37_79B9, ~i * 32'h85EB_CA6B};
      refMem[i] = memArr[i];
    end
    repeat (10) @(posedge clkH);
    #1 arstN = 1'b1;

    checkVal("busy", busy, 0);
    checkVal("loadValid", loadValid, 0);
    checkVal("memWrEn", memWrEn, 0);
    checkVal("memRdEn", memRdEn, 0);
    checkVal("pendIdx", pendIdx, 0);
    $display("test 1 reset: %0d errors", errCnt);

    mark = errCnt;
    for (int sz = 0; sz < 4; sz++)
      for (int off = 0; off < 8; off += (1 << sz))
        access(2'b10, ((sz * 8 + off) << 3) | off, lsuPkg::argSizeT'(sz),
               0, {$random(seed), $random(seed)});
    $display("test 2 writes: %0d errors", errCnt - mark);

    mark = errCnt;
    for (int sz = 0; sz < 4; sz++)
      for (int off = 0; off < 8; off += (1 << sz))
        for (int pat = 0; pat < 4; pat++) begin
          rnd = {$random(seed), $random(seed)};
          rnd = pat[1] ? (rnd | 64'h8080_8080_8080_8080) : (rnd & 64'h7F7F_7F7F_7F7F_7F7F);
          access(2'b10, (64 + sz * 8 + off) << 3 | off, lsuPkg::argSizeT'(sz), 0, rnd);
          access(2'b01, (64 + sz * 8 + off) << 3 | off, lsuPkg::argSizeT'(sz), pat[0], 0);
        end
    $display("test 3 reads: %0d errors", errCnt - mark);

    mark = errCnt;
    for (int n = 0; n < 8; n++) begin
      stall = 1 + {$random(seed)} % 20;
      access(n[0] ? 2'b01 : 2'b10, n << 3, lsuPkg::SizeDword, 0, {$random(seed), 32'h0});
    end
    stall = 0;
    $display("test 4 back-pressure: %0d errors", errCnt - mark);

    mark = errCnt;
    for (int n = 0; n < 300; n++) begin
      argSize = lsuPkg::argSizeT'($random(seed));
      access($random(seed) & 1 ? 2'b01 : 2'b10,
             ({$random(seed)} & 32'h7FF) & ~((32'd1 << argSize) - 1),
             argSize, 1'($random(seed)), {$random(seed), $random(seed)});
    end
    $display("test 5 random mix: %0d errors", errCnt - mark);

    $display("tests 5, errors %0d, protocol errors %0d", errCnt, dut.chk.failCnt);
    if (errCnt == 0 && dut.chk.failCnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: dv/lsuChk.sv
`timescale 1ns/1ps

module lsuChk #(
  parameter int AddrLen = 32
) (
  input logic               clkH,
  input logic               arstN,
  input lsuPkg::memOpT      wrRdEn,
  input logic               busy,
  input logic               memReady,
  input logic [AddrLen-1:3] memAddr,
  input lsuPkg::dataT       memMosi,
  input lsuPkg::laneMaskT   memWrEn,
  input lsuPkg::laneMaskT   memRdEn,
  input logic               loadValid
);

  // Failed assertions, read by the testbench at the end
  int failCnt = 0;

  // ****************************************
  // Protocol rules
  // ****************************************
  noReqWhileBusy: assert property (@(posedge clkH) disable iff (!arstN)
    busy |-> wrRdEn == lsuPkg::OpNone)
    else begin
      $error("request issued while busy");
      failCnt++;
    end

  // Memory side frozen during wait states
  memHoldStable: assert property (@(posedge clkH) disable iff (!arstN)
    ((memWrEn | memRdEn) != '0 && !memReady) |=>
      ($stable(memAddr) && $stable(memMosi) && $stable(memWrEn) && $stable(memRdEn)))
    else begin
      $error("memory outputs changed while not ready");
      failCnt++;
    end

  loadValidPulse: assert property (@(posedge clkH) disable iff (!arstN)
    loadValid |=> !loadValid)
    else begin
      $error("loadValid held longer than one cycle");
      failCnt++;
    end

endmodule

bind lsuTop lsuChk #(.AddrLen(AddrLen)) chk (.*);

// File: hdl/lsuTop.sv
`timescale 1ns/1ps

module lsuTop #(
  parameter int AddrLen = 32
) (
  input  logic               clkH,
  input  logic               arstN,
  input  lsuPkg::memOpT      wrRdEn,
  input  lsuPkg::regIdxT     regIdx,
  input  lsuPkg::argSizeT    argSize,
  input  logic               signExt,
  input  logic [AddrLen-1:0] addr,
  input  lsuPkg::dataT       wrData,
  output logic               busy,
  output lsuPkg::regIdxT     pendIdx,
  output logic               loadValid,
  output lsuPkg::regIdxT     loadIdx,
  output lsuPkg::dataT       loadData,
  output logic [AddrLen-1:3] memAddr,
  output lsuPkg::dataT       memMosi,
  output lsuPkg::laneMaskT   memWrEn,
  output lsuPkg::laneMaskT   memRdEn,
  input  lsuPkg::dataT       memMiso,
  input  logic               memReady
);

  // Request stage to lane aligner
  memReqIf #(.AddrLen(AddrLen)) memBus ();

  lsuIssue #(.AddrLen(AddrLen)) uIssue (
    .clkH      (clkH),
    .arstN     (arstN),
    .wrRdEn    (wrRdEn),
    .regIdx    (regIdx),
    .argSize   (argSize),
    .signExt   (signExt),
    .addr      (addr),
    .wrData    (wrData),
    .memReady  (memReady),
    .mem       (memBus.issue),
    .busy      (busy),
    .pendIdx   (pendIdx),
    .loadValid (loadValid),
    .loadIdx   (loadIdx),
    .loadData  (loadData)
  );

  laneAlign #(.AddrLen(AddrLen)) uAlign (
    .mem      (memBus.align),
    .memReady (memReady),
    .memAddr  (memAddr),
    .memMosi  (memMosi),
    .memWrEn  (memWrEn),
    .memRdEn  (memRdEn),
    .memMiso  (memMiso)
  );

endmodule

// File: hdl/laneAlign.sv
`timescale 1ns/1ps

module laneAlign #(
  parameter int AddrLen = 32
) (
  memReqIf.align             mem,
  input  logic               memReady,
  output logic [AddrLen-1:3] memAddr,
  output lsuPkg::dataT       memMosi,
  output lsuPkg::laneMaskT   memWrEn,
  output lsuPkg::laneMaskT   memRdEn,
  input  lsuPkg::dataT       memMiso
);

  logic [2:0]       laneOff;
  logic [5:0]       bitOff;
  lsuPkg::laneMaskT sizeMask;
  lsuPkg::laneMaskT laneMask;
  lsuPkg::dataT     byteMask;
  lsuPkg::dataT     rdShifted;
  lsuPkg::dataT     signFill;
  logic             signBit;

  // Byte offset inside the beat
  assign laneOff = mem.addr[2:0];
  assign bitOff  = {laneOff, 3'b000};

  // ****************************************
  // Size decode
  // ****************************************
  always_comb begin
    rdShifted = memMiso >> bitOff;
    unique case (mem.size)
      lsuPkg::SizeByte: begin
        sizeMask = 8'h01;
        signBit  = rdShifted[7];
      end
      lsuPkg::SizeHalf: begin
        sizeMask = 8'h03;
        signBit  = rdShifted[15];
      end
      lsuPkg::SizeWord: begin
        sizeMask = 8'h0F;
        signBit  = rdShifted[31];
      end
      lsuPkg::SizeDword: begin
        sizeMask = 8'hFF;
        signBit  = 1'b0;
      end
    endcase
  end

  // One byte of data mask per lane
  always_comb begin
    for (int i = 0; i < lsuPkg::LaneCnt; i++) begin
      byteMask[8*i +: 8] = {8{sizeMask[i]}};
    end
  end

  // ****************************************
  // Write path
  // ****************************************
  assign laneMask = mem.valid ? lsuPkg::laneMaskT'(sizeMask << laneOff) : '0;
  assign memWrEn  = mem.op[lsuPkg::OpWrBit] ? laneMask : '0;
  assign memRdEn  = mem.op[lsuPkg::OpRdBit] ? laneMask : '0;
  assign memMosi  = (mem.data & byteMask) << bitOff;
  assign memAddr  = mem.addr[AddrLen-1:3];

  // ****************************************
  // Read path
  // ****************************************
  // Upper bytes copy the top kept bit, dword has none above it
  assign signFill = (mem.signExt && signBit) ? ~byteMask : '0;

  assign mem.rdData = (memReady && mem.op[lsuPkg::OpRdBit])
                      ? ((rdShifted & byteMask) | signFill) : '0;

endmodule

// File: hdl/lsuIssue.sv
`timescale 1ns/1ps

module lsuIssue #(
  parameter int AddrLen = 32
) (
  input  logic               clkH,
  input  logic               arstN,
  input  lsuPkg::memOpT      wrRdEn,
  input  lsuPkg::regIdxT     regIdx,
  input  lsuPkg::argSizeT    argSize,
  input  logic               signExt,
  input  logic [AddrLen-1:0] addr,
  input  lsuPkg::dataT       wrData,
  input  logic               memReady,
  memReqIf.issue             mem,
  output logic               busy,
  output lsuPkg::regIdxT     pendIdx,
  output logic               loadValid,
  output lsuPkg::regIdxT     loadIdx,
  output lsuPkg::dataT       loadData
);

  logic          accept;
  logic          done;
  lsuPkg::memOpT acceptOp;

  // New requests only while idle
  assign accept   = !busy && (wrRdEn != lsuPkg::OpNone);
  assign done     = mem.valid && memReady;
  assign acceptOp = accept ? wrRdEn : lsuPkg::OpNone;

  // ****************************************
  // Request stage
  // ****************************************
  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      mem.valid <= 1'b0;
      mem.op    <= lsuPkg::OpNone;
    end else if (accept) begin
      mem.valid <= 1'b1;
      mem.op    <= wrRdEn;
    end else if (done) begin
      mem.valid <= 1'b0;
      mem.op    <= lsuPkg::OpNone;
    end
  end

  // Held stable until the access closes
  always_ff @(posedge clkH) begin
    if (accept) begin
      mem.addr    <= addr;
      mem.data    <= wrData;
      mem.size    <= argSize;
      mem.signExt <= signExt;
    end
  end

  // Pending index and load return
  lsuReqTracker uTracker (
    .clkH      (clkH),
    .arstN     (arstN),
    .accept    (acceptOp),
    .acceptIdx (regIdx),
    .memReady  (memReady),
    .rdData    (mem.rdData),
    .busy      (busy),
    .pendIdx   (pendIdx),
    .loadValid (loadValid),
    .loadIdx   (loadIdx),
    .loadData  (loadData)
  );

endmodule

// File: hdl/lsuReqTracker.sv
`timescale 1ns/1ps

module lsuReqTracker (
  input  logic           clkH,
  input  logic           arstN,
  input  lsuPkg::memOpT  accept,
  input  lsuPkg::regIdxT acceptIdx,
  input  logic           memReady,
  input  lsuPkg::dataT   rdData,
  output logic           busy,
  output lsuPkg::regIdxT pendIdx,
  output logic           loadValid,
  output lsuPkg::regIdxT loadIdx,
  output lsuPkg::dataT   loadData
);

  logic          pending;
  lsuPkg::memOpT oper;
  logic          acceptNZ;
  logic          done;
  logic          loadDone;

  assign acceptNZ = accept != lsuPkg::OpNone;

  // Access closes on the first ready edge while open
  assign done     = pending && memReady;
  assign loadDone = done && oper[lsuPkg::OpRdBit];

  // ****************************************
  // Pending access
  // ****************************************
  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      pending <= 1'b0;
      oper    <= lsuPkg::OpNone;
      pendIdx <= '0;
    end else if (acceptNZ) begin
      pending <= 1'b1;
      oper    <= accept;
      pendIdx <= acceptIdx;
    end else if (done) begin
      pending <= 1'b0;
      oper    <= lsuPkg::OpNone;
      pendIdx <= '0;
    end
  end

  // Single cycle strobe after a read completes
  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      loadValid <= 1'b0;
    end else begin
      loadValid <= loadDone;
    end
  end

  // ****************************************
  // Load result
  // ****************************************
  always_ff @(posedge clkH) begin
    if (loadDone) begin
      loadData <= rdData;
      loadIdx  <= pendIdx;
    end
  end

  assign busy = pending;

endmodule

// File: hdl/memReqIf.sv
`timescale 1ns/1ps

interface memReqIf #(
  parameter int AddrLen = 32
);
  // Registered request
  logic                 valid;
  lsuPkg::memOpT        op;
  logic [AddrLen-1:0]   addr;
  lsuPkg::dataT         data;
  lsuPkg::argSizeT      size;
  logic                 signExt;

  // Aligned and extended load word
  lsuPkg::dataT         rdData;

  modport issue (
    output valid, op, addr, data, size, signExt,
    input  rdData
  );

  modport align (
    input  valid, op, addr, data, size, signExt,
    output rdData
  );

endinterface

// File: hdl/lsuPkg.sv
package lsuPkg;

  // ****************************************
  // Widths
  // ****************************************
  localparam int DataLen   = 64;
  localparam int LaneCnt   = 8;
  localparam int RegIdxLen = 12;

  typedef logic [DataLen-1:0]   dataT;
  typedef logic [LaneCnt-1:0]   laneMaskT;
  typedef logic [RegIdxLen-1:0] regIdxT;

  // Access size in bytes is 1 << size
  typedef enum logic [1:0] {
    SizeByte  = 2'd0,
    SizeHalf  = 2'd1,
    SizeWord  = 2'd2,
    SizeDword = 2'd3
  } argSizeT;

  // ****************************************
  // Operation code
  // ****************************************
  // Upper bit writes, lower bit reads
  typedef logic [1:0] memOpT;

  localparam memOpT OpNone = 2'b00;

  // Bit positions inside memOpT
  localparam int OpWrBit = 1;
  localparam int OpRdBit = 0;

endpackage
